//--- vlog.f
logic/cpu_types_pkg.sv
logic/dcache_if.sv
logic/dcache_tags.sv
logic/dcache_ctrl.sv
logic/dcache_data.sv
logic/dcache.sv
dv/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert --top-module dcache_tb -f vlog.f -o dcache_sim > build.log 2>&1 &&
./obj_dir/dcache_sim > sim.log 2>&1 &&
! grep -q "Simulation failed" sim.log &&
echo "PASS" ||
{ cat build.log sim.log 2>/dev/null; echo "FAIL"; exit 1; }

//--- dv/dcache_tb.sv
`timescale 1ns/100ps

module dcache_tb import cpu_types_pkg::*; ();

   localparam int NUM_OPS       = 400;
   localparam int REQ_TIMEOUT   = 100;   // cycles per request
   localparam int FLUSH_TIMEOUT = 1000;

   logic  CLK;
   logic  nRST;
   logic  dmemREN;
   logic  dmemWEN;
   logic  halt;
   word_t dmemaddr;
   word_t dmemstore;
   logic  dhit;
   logic  flushed;
   word_t dmemload;
   logic  dREN;
   logic  dWEN;
   word_t daddr;
   word_t dstore;
   word_t dload;
   logic  dwait;

   // reference cache state
   tag_t  m_tag   [2][NUM_SETS];
   logic  m_valid [2][NUM_SETS];
   logic  m_dirty [2][NUM_SETS];
   way_t  m_lru   [NUM_SETS];
   word_t coherent [word_t];      // last stored value per address
   word_t mem_model [word_t];
   word_t wr_addr_q [$];
   word_t wr_data_q [$];
   int    rd_count;
   int    exp_count;
   int    err_count;
   int    timeout_count;
   logic  busy;
   int    wait_left;

   dcache dcache_i (.*);

   initial CLK = 1'b0;
   always #2 CLK = ~CLK;

   function automatic word_t init_word(word_t addr);
      return (addr * 32'h9e37_79b1) ^ 32'h0bad_cafe;
   endfunction

   function automatic word_t read_mem(word_t addr);
      if (mem_model.exists(addr))
         return mem_model[addr];
      return init_word(addr);
   endfunction

   function automatic word_t expected_word(word_t addr);
      if (coherent.exists(addr))
         return coherent[addr];
      return init_word(addr);
   endfunction

   task automatic check_value(string name, word_t got, word_t exp);
      if (got !== exp)
      begin
         err_count++;
         $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // memory model answers one transfer at a time with 0 to 2 wait cycles
   always @(negedge CLK)
   begin
      if (dREN || dWEN)
      begin
         if (!busy)
         begin
            check_value("dREN & dWEN", {31'b0, dREN & dWEN}, 32'h0);
            check_value("daddr[1:0]", {30'b0, daddr[1:0]}, 32'h0);
            busy      = 1'b1;
            wait_left = $urandom_range(2, 0);
         end
         if (wait_left > 0)
         begin
            dwait = 1'b1;
            wait_left--;
         end
         else
         begin
            dwait = 1'b0;        // transfer completes at the next rising edge
            busy  = 1'b0;
            if (dWEN)
            begin
               mem_model[daddr] = dstore;
               wr_addr_q.push_back(daddr);
               wr_data_q.push_back(dstore);
            end
            else
            begin
               dload = read_mem(daddr);
               rd_count++;
            end
         end
      end
      else
         dwait = 1'b0;
   end

   task automatic run_access();
      logic  is_store;
      tag_t  tag;
      idx_t  idx;
      logic  wsel;
      word_t addr;
      word_t data;
      logic  exp_hit;
      way_t  hw;
      logic  vic_dirty;
      tag_t  vic_tag;
      word_t wb_addr;
      int    exp_writes;
      int    cycles;
      is_store = 1'($urandom_range(1, 0));
      tag      = tag_t'($urandom_range(3, 0) + 1);
      idx      = idx_t'($urandom_range(7, 0));
      wsel     = 1'($urandom_range(1, 0));
      addr     = {tag, idx, wsel, 2'b00};
      data     = $urandom;
      exp_hit  = 1'b0;
      hw       = 1'b0;
      for (int w = 0; w < 2; w++)
      begin
         if (m_valid[w][idx] && m_tag[w][idx] == tag)
         begin
            exp_hit = 1'b1;
            hw      = 1'(w);
         end
      end
      dmemaddr  = addr;
      dmemstore = data;
      dmemREN   = !is_store;
      dmemWEN   = is_store;
      #1;
      check_value("dhit", {31'b0, dhit}, {31'b0, exp_hit});
      cycles = 0;
      while (!dhit && cycles < REQ_TIMEOUT)
      begin
         @(negedge CLK);
         #1;
         cycles++;
      end
      if (!dhit)
      begin
         $display("timeout: request to address %h never got dhit", addr);
         timeout_count++;
         return;
      end
      if (!is_store)
         check_value("dmemload", dmemload, expected_word(addr));
      exp_writes = 0;
      if (!exp_hit)
      begin
         hw        = m_lru[idx];
         vic_dirty = m_dirty[hw][idx];
         vic_tag   = m_tag[hw][idx];
         exp_writes = vic_dirty ? 2 : 0;
         if (vic_dirty && wr_addr_q.size() == 2)
         begin
            for (int i = 0; i < 2; i++)
            begin
               wb_addr = {vic_tag, idx, 1'(i), 2'b00};
               check_value("write-back daddr", wr_addr_q[i], wb_addr);
               check_value("write-back dstore", wr_data_q[i], expected_word(wb_addr));
            end
         end
         m_tag[hw][idx]   = tag;
         m_valid[hw][idx] = 1'b1;
         m_dirty[hw][idx] = 1'b0;
         exp_count -= 1;   // the miss cycle
      end
      check_value("bus write count", wr_addr_q.size(), exp_writes);
      check_value("bus read count", rd_count, exp_hit ? 0 : 2);
      m_lru[idx] = ~hw;
      if (is_store)
      begin
         m_dirty[hw][idx] = 1'b1;
         coherent[addr]   = data;
      end
      exp_count += 1;
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_count = 0;
   endtask

   task automatic check_memory();
      foreach (coherent[a])
         check_value($sformatf("mem[%h]", a), read_mem(a), coherent[a]);
      check_value("hit counter word", read_mem(HIT_COUNT_ADDR), word_t'(exp_count));
   endtask

   initial
   begin
      int cycles;
      void'($urandom(32'h9da4f3a1));
      err_count     = 0;
      timeout_count = 0;
      exp_count     = 0;
      rd_count      = 0;
      busy          = 1'b0;
      wait_left     = 0;
      nRST          = 1'b0;
      dmemREN       = 1'b0;
      dmemWEN       = 1'b0;
      halt          = 1'b0;
      dmemaddr      = '0;
      dmemstore     = '0;
      dload         = '0;
      dwait         = 1'b0;
      for (int s = 0; s < NUM_SETS; s++)
      begin
         m_valid[0][s] = 1'b0;
         m_valid[1][s] = 1'b0;
         m_dirty[0][s] = 1'b0;
         m_dirty[1][s] = 1'b0;
         m_lru[s]      = 1'b0;
      end
      repeat (10) @(negedge CLK);
      nRST = 1'b1;
      #1;
      check_value("dREN", {31'b0, dREN}, 32'h0);
      check_value("dWEN", {31'b0, dWEN}, 32'h0);
      check_value("dhit", {31'b0, dhit}, 32'h0);
      check_value("flushed", {31'b0, flushed}, 32'h0);
      for (int n = 0; n < NUM_OPS && timeout_count == 0; n++)
      begin
         @(negedge CLK);
         run_access();
      end
      if (timeout_count == 0)
      begin
         @(negedge CLK);
         dmemREN = 1'b0;
         dmemWEN = 1'b0;
         halt    = 1'b1;
         cycles  = 0;
         while (!flushed && cycles < FLUSH_TIMEOUT)
         begin
            @(negedge CLK);
            #1;
            cycles++;
         end
         if (!flushed)
         begin
            $display("timeout: flushed never went high after halt");
            timeout_count++;
         end
         else
            check_memory();
      end
      $display("errors: %0d, timeouts: %0d", err_count, timeout_count);
      if (err_count == 0 && timeout_count == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- logic/dcache.sv
`timescale 1ns/100ps

module dcache import cpu_types_pkg::*; (
   input  logic  CLK,
   input  logic  nRST,
   // datapath side
   input  logic  dmemREN,
   input  logic  dmemWEN,
   input  logic  halt,
   input  word_t dmemaddr,
   input  word_t dmemstore,
   output logic  dhit,
   output logic  flushed,
   output word_t dmemload,
   // memory side
   output logic  dREN,
   output logic  dWEN,
   output word_t daddr,
   output word_t dstore,
   input  word_t dload,
   input  logic  dwait
);

   tag_port_if  tp ();
   data_port_if dp ();

   assign dmemload = dp.rdata;   // valid in the dhit cycle

   dcache_tags tags_i (
      .CLK  (CLK),
      .nRST (nRST),
      .tp   (tp.tags)
   );

   dcache_ctrl ctrl_i (
      .CLK       (CLK),
      .nRST      (nRST),
      .dmemREN   (dmemREN),
      .dmemWEN   (dmemWEN),
      .halt      (halt),
      .dmemaddr  (dmemaddr),
      .dmemstore (dmemstore),
      .dhit      (dhit),
      .flushed   (flushed),
      .dREN      (dREN),
      .dWEN      (dWEN),
      .daddr     (daddr),
      .dstore    (dstore),
      .dload     (dload),
      .dwait     (dwait),
      .tp        (tp.ctrl),
      .dp        (dp.ctrl)
   );

   dcache_data data_i (
      .CLK  (CLK),
      .nRST (nRST),
      .dp   (dp.data)
   );

endmodule

//--- logic/dcache_data.sv
`timescale 1ns/100ps

module dcache_data import cpu_types_pkg::*; (
   input logic       CLK,
   input logic       nRST,
   data_port_if.data dp
);

   // way, set, word within the block
   word_t mem [2][NUM_SETS][2];

   always_ff @(posedge CLK)
   begin
      if (dp.wr)
      begin
         mem[dp.way][dp.index][dp.word_sel] <= dp.wdata;
      end
   end

   // serves both the load path and write-back data
   assign dp.rdata = mem[dp.rd_way][dp.rd_index][dp.rd_word_sel];

   // store data and refill beats from the bus must be known when written
   wdata_known: assert property (@(posedge CLK) disable iff (!nRST)
      dp.wr |-> !$isunknown({dp.way, dp.index, dp.word_sel, dp.wdata}));

endmodule

//--- logic/dcache_ctrl.sv
`timescale 1ns/100ps

module dcache_ctrl import cpu_types_pkg::*; (
   input  logic       CLK,
   input  logic       nRST,
   input  logic       dmemREN,
   input  logic       dmemWEN,
   input  logic       halt,
   input  word_t      dmemaddr,
   input  word_t      dmemstore,
   output logic       dhit,
   output logic       flushed,
   output logic       dREN,
   output logic       dWEN,
   output word_t      daddr,
   output word_t      dstore,
   input  word_t      dload,
   input  logic       dwait,
   tag_port_if.ctrl   tp,
   data_port_if.ctrl  dp
);

   typedef enum logic [3:0] {
      IDLE, WB1, WB2, READ1, READ2, DIRTY, FLUSH1, FLUSH2, COUNT, HALT
   } dcache_state_t;

   dcache_state_t state, next_state;

   tag_t       req_tag;
   idx_t       req_index;
   logic       req_word;
   logic       request;
   logic       req_hit;
   way_t       victim_q, next_victim;
   logic [4:0] scan_row, next_scan_row;   // 0..7 left way, 8..15 right way, 16 done
   word_t      hit_count, next_hit_count;

   assign req_tag   = dmemaddr[31:6];
   assign req_index = dmemaddr[5:3];
   assign req_word  = dmemaddr[2];
   assign request   = dmemREN | dmemWEN;
   assign req_hit   = (state == IDLE) && !halt && request && tp.hit;

   assign dhit    = req_hit;
   assign flushed = (state == HALT);

   assign tp.index      = req_index;
   assign tp.lookup_tag = req_tag;
   assign tp.set_dirty  = req_hit & dmemWEN;
   assign tp.touch      = req_hit;
   assign tp.touch_way  = tp.hit_way;
   assign tp.fill       = (state == READ2) && !dwait;  // tag goes valid with the last beat
   assign tp.fill_way   = victim_q;
   assign tp.scan_way   = scan_row[3];
   assign tp.scan_index = scan_row[2:0];

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         state     <= IDLE;
         victim_q  <= 1'b0;
         scan_row  <= '0;
         hit_count <= '0;
      end
      else
      begin
         state     <= next_state;
         victim_q  <= next_victim;
         scan_row  <= next_scan_row;
         hit_count <= next_hit_count;
      end
   end

   always_comb
   begin
      next_state     = state;
      next_victim    = victim_q;
      next_scan_row  = scan_row;
      next_hit_count = hit_count;
      case (state)
         IDLE:
         begin
            if (halt)
               next_state = DIRTY;
            else if (request && tp.hit)
               next_hit_count = hit_count + 1;
            else if (request)
            begin
               next_hit_count = hit_count - 1;
               next_victim    = tp.victim_way;  // held through write-back and refill
               next_state     = tp.victim_dirty ? WB1 : READ1;
            end
         end
         WB1:    if (!dwait) next_state = WB2;
         WB2:    if (!dwait) next_state = READ1;
         READ1:  if (!dwait) next_state = READ2;
         READ2:  if (!dwait) next_state = IDLE;
         DIRTY:
         begin
            if (scan_row == 5'(2 * NUM_SETS))
               next_state = COUNT;
            else if (tp.scan_dirty)
               next_state = FLUSH1;
            else
               next_scan_row = scan_row + 5'd1;
         end
         FLUSH1: if (!dwait) next_state = FLUSH2;
         FLUSH2:
         begin
            if (!dwait)
            begin
               next_state    = DIRTY;
               next_scan_row = scan_row + 5'd1;
            end
         end
         COUNT:  if (!dwait) next_state = HALT;
         default: next_state = state;   // HALT holds until reset
      endcase
   end

   always_comb
   begin
      dREN           = 1'b0;
      dWEN           = 1'b0;
      daddr          = '0;
      dstore         = dp.rdata;
      dp.wr          = 1'b0;
      dp.way         = victim_q;
      dp.index       = req_index;
      dp.word_sel    = req_word;
      dp.wdata       = dmemstore;
      dp.rd_way      = tp.hit_way;
      dp.rd_index    = req_index;
      dp.rd_word_sel = req_word;
      case (state)
         IDLE:
         begin
            dp.wr  = req_hit & dmemWEN;
            dp.way = tp.hit_way;
         end
         WB1, WB2:
         begin
            dWEN           = 1'b1;
            dp.rd_way      = victim_q;
            dp.rd_word_sel = (state == WB2);
            daddr          = {tp.victim_tag, req_index, dp.rd_word_sel, 2'b00};
         end
         READ1, READ2:
         begin
            dREN        = 1'b1;
            dp.wr       = !dwait;
            dp.word_sel = (state == READ2);
            dp.wdata    = dload;
            daddr       = {req_tag, req_index, dp.word_sel, 2'b00};
         end
         FLUSH1, FLUSH2:
         begin
            dWEN           = 1'b1;
            dp.rd_way      = tp.scan_way;
            dp.rd_index    = tp.scan_index;
            dp.rd_word_sel = (state == FLUSH2);
            daddr          = {tp.scan_tag, tp.scan_index, dp.rd_word_sel, 2'b00};
         end
         COUNT:
         begin
            dWEN   = 1'b1;
            daddr  = HIT_COUNT_ADDR;
            dstore = hit_count;
         end
         default: dWEN = 1'b0;
      endcase
   end

   bus_exclusive: assert property (@(posedge CLK) disable iff (!nRST) !(dREN && dWEN));

   flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST) flushed |=> flushed);

endmodule

//--- logic/dcache_tags.sv
`timescale 1ns/100ps

module dcache_tags import cpu_types_pkg::*; (
   input logic      CLK,
   input logic      nRST,
   tag_port_if.tags tp
);

   tag_t tags  [2][NUM_SETS];
   logic valid [2][NUM_SETS];
   logic dirty [2][NUM_SETS];
   logic [NUM_SETS-1:0] lru;               // names the next victim way per set

   logic hit_left;
   logic hit_right;
   way_t victim;

   assign hit_left  = valid[0][tp.index] && (tags[0][tp.index] == tp.lookup_tag);
   assign hit_right = valid[1][tp.index] && (tags[1][tp.index] == tp.lookup_tag);

   assign tp.hit     = hit_left | hit_right;
   assign tp.hit_way = hit_right;          // a tag lives in at most one way

   assign victim          = lru[tp.index];
   assign tp.victim_way   = victim;
   assign tp.victim_dirty = dirty[victim][tp.index];
   assign tp.victim_tag   = tags[victim][tp.index];

   // flush scan may read any row regardless of the request index
   assign tp.scan_dirty = dirty[tp.scan_way][tp.scan_index];
   assign tp.scan_tag   = tags[tp.scan_way][tp.scan_index];

   always_ff @(posedge CLK)
   begin
      if (tp.fill)
      begin
         tags[tp.fill_way][tp.index] <= tp.lookup_tag;
      end
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int s = 0; s < NUM_SETS; s++)
         begin
            valid[0][s] <= 1'b0;
            valid[1][s] <= 1'b0;
            dirty[0][s] <= 1'b0;
            dirty[1][s] <= 1'b0;
         end
         lru <= '0;                        // left way goes first
      end
      else
      begin
         if (tp.fill)
         begin
            valid[tp.fill_way][tp.index] <= 1'b1;
            dirty[tp.fill_way][tp.index] <= 1'b0;
            lru[tp.index]                <= ~tp.fill_way;
         end
         if (tp.set_dirty)
         begin
            dirty[tp.hit_way][tp.index] <= 1'b1;
         end
         if (tp.touch)
         begin
            lru[tp.index] <= ~tp.touch_way;  // most recent way is spared
         end
      end
   end

   // refill and store hit are never in the same cycle
   fill_vs_store: assert property (@(posedge CLK) disable iff (!nRST)
      !(tp.fill && tp.set_dirty));

endmodule

//--- logic/dcache_if.sv
`timescale 1ns/100ps

interface tag_port_if import cpu_types_pkg::*; ();
   idx_t  index;
   tag_t  lookup_tag;
   logic  set_dirty;
   logic  fill;
   way_t  fill_way;
   logic  touch;
   way_t  touch_way;
   logic  hit;
   way_t  hit_way;
   way_t  victim_way;
   logic  victim_dirty;
   tag_t  victim_tag;
   way_t  scan_way;          // flush scan row select
   idx_t  scan_index;
   logic  scan_dirty;
   tag_t  scan_tag;

   modport ctrl (
      output index, lookup_tag, set_dirty, fill, fill_way, touch, touch_way,
      output scan_way, scan_index,
      input  hit, hit_way, victim_way, victim_dirty, victim_tag, scan_dirty, scan_tag
   );

   modport tags (
      input  index, lookup_tag, set_dirty, fill, fill_way, touch, touch_way,
      input  scan_way, scan_index,
      output hit, hit_way, victim_way, victim_dirty, victim_tag, scan_dirty, scan_tag
   );
endinterface

interface data_port_if import cpu_types_pkg::*; ();
   logic  wr;
   way_t  way;
   idx_t  index;
   logic  word_sel;
   word_t wdata;
   way_t  rd_way;            // read side is independent of the write side
   idx_t  rd_index;
   logic  rd_word_sel;
   word_t rdata;

   modport ctrl (
      output wr, way, index, word_sel, wdata, rd_way, rd_index, rd_word_sel,
      input  rdata
   );

   modport data (
      input  wr, way, index, word_sel, wdata, rd_way, rd_index, rd_word_sel,
      output rdata
   );
endinterface

//--- logic/cpu_types_pkg.sv
package cpu_types_pkg;

   // data word and byte address
   typedef logic [31:0] word_t;

   // address split is tag[31:6], index[5:3], word[2], byte[1:0]
   typedef logic [25:0] tag_t;
   typedef logic [2:0]  idx_t;

   // 0 is the left way, 1 is the right way
   typedef logic        way_t;

   // number of sets with two ways each
   localparam int NUM_SETS = 8;

   localparam word_t HIT_COUNT_ADDR = 32'h0000_3100;   // hit counter lands here on halt

endpackage
